/* Bender.yml */
package:
  name: efpga_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/efpga_pkg.sv
      - hdl/tcdm_port_if.sv
      - hdl/efpga_control_sync.sv
      - hdl/tcdm_port_slice.sv
      - hdl/lint_grant_gate.sv
      - hdl/event_pulse_sync.sv
      - hdl/efpga_subsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_efpga_subsystem.sv

/* filelist.f */
+incdir+include
hdl/efpga_pkg.sv
hdl/tcdm_port_if.sv
hdl/efpga_control_sync.sv
hdl/tcdm_port_slice.sv
hdl/lint_grant_gate.sv
hdl/event_pulse_sync.sv
hdl/efpga_subsystem.sv
tb/tb_efpga_subsystem.sv

/* hdl/efpga_control_sync.sv */
// stability filter for the fabric control word
// output only takes a value after three matching samples

`timescale 1ns/1ps
`default_nettype none

module efpga_control_sync (
  input  wire logic                     asic_clk_i,
  input  wire logic                     rst_n,
  input  wire efpga_pkg::control_word_t control_i,
  output efpga_pkg::control_word_t      control_word_o
);

  efpga_pkg::control_word_t sample_d1;
  efpga_pkg::control_word_t sample_d2;
  logic                     stable_q;

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      sample_d1 <= '0;
      sample_d2 <= '0;
      stable_q  <= 1'b0;
    end else begin
      sample_d1 <= control_i;
      sample_d2 <= sample_d1;
      stable_q  <= (sample_d1 == control_i) && (sample_d2 == control_i);
    end
  end

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      control_word_o <= '0;
    end else if (stable_q) begin
      control_word_o <= sample_d1;  // matched input for three edges
    end
  end

endmodule

`default_nettype wire

/* hdl/efpga_pkg.sv */
// shared vector types and event channel states for the eFPGA glue

`default_nettype none

`include "efpga_defines.svh"

package efpga_pkg;

  typedef logic [`EFPGA_DATA_W-1:0] data_t;
  typedef logic [`EFPGA_BE_W-1:0]   be_t;
  typedef logic [`EFPGA_ADDR_W-1:0] fpga_addr_t;  // offset inside the window
  typedef logic [`SOC_ADDR_W-1:0]   soc_addr_t;

  typedef logic [31:0] control_word_t;

  typedef logic [`EFPGA_EVENTS-1:0] event_vec_t;

  // per-event transfer into the SoC domain
  typedef enum logic [1:0] {
    evt_idle    = 2'd0,
    evt_send    = 2'd1,  // level raised, waiting for ack
    evt_release = 2'd2   // waiting for ack to drop
  } evt_state_e;

endpackage

`default_nettype wire

/* hdl/efpga_subsystem.sv */
// eFPGA fabric-facing glue: control filter, TCDM slices, lint gate, event pulses
// fabric signals arrive as plain ports, all logic on asic_clk_i

`timescale 1ns/1ps
`default_nettype none

`include "efpga_defines.svh"

module efpga_subsystem (
  input  wire logic                                            asic_clk_i,
  input  wire logic                                            rst_n,
  input  wire efpga_pkg::control_word_t                        control_in_i,
  output efpga_pkg::control_word_t                             control_word_o,
  input  wire logic [`EFPGA_TCDM_PORTS-1:0]                    enable_tcdm_i,
  input  wire logic                                            enable_apb_i,
  input  wire logic                                            enable_events_i,
  input  wire logic [`EFPGA_TCDM_PORTS-1:0]                    fab_tcdm_req_i,
  input  wire logic [`EFPGA_TCDM_PORTS-1:0]                    fab_tcdm_wen_i,
  input  wire efpga_pkg::fpga_addr_t [`EFPGA_TCDM_PORTS-1:0]   fab_tcdm_addr_i,
  input  wire efpga_pkg::be_t [`EFPGA_TCDM_PORTS-1:0]          fab_tcdm_be_i,
  input  wire efpga_pkg::data_t [`EFPGA_TCDM_PORTS-1:0]        fab_tcdm_wdata_i,
  output logic [`EFPGA_TCDM_PORTS-1:0]                         fab_tcdm_gnt_o,
  output logic [`EFPGA_TCDM_PORTS-1:0]                         fab_tcdm_r_valid_o,
  output efpga_pkg::data_t [`EFPGA_TCDM_PORTS-1:0]             fab_tcdm_rdata_o,
  output logic [`EFPGA_TCDM_PORTS-1:0]                         soc_tcdm_req_o,
  output efpga_pkg::soc_addr_t [`EFPGA_TCDM_PORTS-1:0]         soc_tcdm_addr_o,
  output logic [`EFPGA_TCDM_PORTS-1:0]                         soc_tcdm_wen_o,
  output efpga_pkg::be_t [`EFPGA_TCDM_PORTS-1:0]               soc_tcdm_be_o,
  output efpga_pkg::data_t [`EFPGA_TCDM_PORTS-1:0]             soc_tcdm_wdata_o,
  input  wire logic [`EFPGA_TCDM_PORTS-1:0]                    soc_tcdm_gnt_i,
  input  wire logic [`EFPGA_TCDM_PORTS-1:0]                    soc_tcdm_r_valid_i,
  input  wire efpga_pkg::data_t [`EFPGA_TCDM_PORTS-1:0]        soc_tcdm_rdata_i,
  input  wire logic                                            lint_req_i,
  input  wire logic                                            lint_wen_i,
  input  wire efpga_pkg::fpga_addr_t                           lint_addr_i,
  input  wire efpga_pkg::be_t                                  lint_be_i,
  input  wire efpga_pkg::data_t                                lint_wdata_i,
  output logic                                                 lint_gnt_o,
  output logic                                                 lint_r_valid_o,
  output efpga_pkg::data_t                                     lint_rdata_o,
  output logic                                                 fab_lint_req_o,
  output logic                                                 fab_lint_wen_o,
  output efpga_pkg::fpga_addr_t                                fab_lint_addr_o,
  output efpga_pkg::be_t                                       fab_lint_be_o,
  output efpga_pkg::data_t                                     fab_lint_wdata_o,
  input  wire logic                                            fab_lint_gnt_i,
  input  wire logic                                            fab_lint_r_valid_i,
  input  wire efpga_pkg::data_t                                fab_lint_rdata_i,
  input  wire efpga_pkg::event_vec_t                           events_i,
  output efpga_pkg::event_vec_t                                efpga_event_o
);

  efpga_control_sync i_control_sync (
    .asic_clk_i     (asic_clk_i),
    .rst_n          (rst_n),
    .control_i      (control_in_i),
    .control_word_o (control_word_o)
  );

  for (genvar g_tcdm = 0; g_tcdm < `EFPGA_TCDM_PORTS; g_tcdm++) begin : g_tcdm_port
    tcdm_port_if i_fab_port ();

    assign i_fab_port.req   = fab_tcdm_req_i[g_tcdm];
    assign i_fab_port.wen   = fab_tcdm_wen_i[g_tcdm];
    assign i_fab_port.addr  = fab_tcdm_addr_i[g_tcdm];
    assign i_fab_port.be    = fab_tcdm_be_i[g_tcdm];
    assign i_fab_port.wdata = fab_tcdm_wdata_i[g_tcdm];

    assign fab_tcdm_gnt_o[g_tcdm]     = i_fab_port.gnt;
    assign fab_tcdm_r_valid_o[g_tcdm] = i_fab_port.r_valid;
    assign fab_tcdm_rdata_o[g_tcdm]   = i_fab_port.rdata;

    tcdm_port_slice i_slice (
      .asic_clk_i    (asic_clk_i),
      .rst_n         (rst_n),
      .enable_i      (enable_tcdm_i[g_tcdm]),
      .fab           (i_fab_port.slice),
      .soc_req_o     (soc_tcdm_req_o[g_tcdm]),
      .soc_addr_o    (soc_tcdm_addr_o[g_tcdm]),
      .soc_wen_o     (soc_tcdm_wen_o[g_tcdm]),
      .soc_be_o      (soc_tcdm_be_o[g_tcdm]),
      .soc_wdata_o   (soc_tcdm_wdata_o[g_tcdm]),
      .soc_gnt_i     (soc_tcdm_gnt_i[g_tcdm]),
      .soc_r_valid_i (soc_tcdm_r_valid_i[g_tcdm]),
      .soc_rdata_i   (soc_tcdm_rdata_i[g_tcdm])
    );
  end

  lint_grant_gate i_lint_gate (
    .asic_clk_i     (asic_clk_i),
    .rst_n          (rst_n),
    .enable_i       (enable_apb_i),
    .lint_req_i     (lint_req_i),
    .lint_gnt_o     (lint_gnt_o),
    .lint_r_valid_o (lint_r_valid_o),
    .lint_rdata_o   (lint_rdata_o),
    .fab_req_o      (fab_lint_req_o),
    .fab_gnt_i      (fab_lint_gnt_i),
    .fab_r_valid_i  (fab_lint_r_valid_i),
    .fab_rdata_i    (fab_lint_rdata_i)
  );

  // lint payload goes to the fabric unchanged
  assign fab_lint_wen_o   = lint_wen_i;
  assign fab_lint_addr_o  = lint_addr_i;
  assign fab_lint_be_o    = lint_be_i;
  assign fab_lint_wdata_o = lint_wdata_i;

  for (genvar g_evt = 0; g_evt < `EFPGA_EVENTS; g_evt++) begin : g_event
    event_pulse_sync i_event_sync (
      .asic_clk_i    (asic_clk_i),
      .rst_n         (rst_n),
      .event_i       (events_i[g_evt]),
      .enable_i      (enable_events_i),
      .event_pulse_o (efpga_event_o[g_evt])
    );
  end

endmodule

`default_nettype wire

/* hdl/event_pulse_sync.sv */
// one fabric event into a single-cycle SoC pulse
// valid level crosses a two-flop synchronizer, synced level is the ack

`timescale 1ns/1ps
`default_nettype none

module event_pulse_sync (
  input  wire logic asic_clk_i,
  input  wire logic rst_n,
  input  wire logic event_i,
  input  wire logic enable_i,
  output logic      event_pulse_o
);

  efpga_pkg::evt_state_e state_q;
  logic                  evt_gated;
  logic                  evt_prev_q;
  logic                  evt_rise;
  logic                  send_sync_q1;
  logic                  send_sync_q2;
  logic                  ack_prev_q;

  assign evt_gated = event_i & enable_i;
  assign evt_rise  = evt_gated & ~evt_prev_q;

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= efpga_pkg::evt_idle;
      evt_prev_q <= 1'b0;
    end else begin
      evt_prev_q <= evt_gated;
      case (state_q)
        efpga_pkg::evt_idle: begin
          if (evt_rise) state_q <= efpga_pkg::evt_send;
        end
        efpga_pkg::evt_send: begin
          if (send_sync_q2) state_q <= efpga_pkg::evt_release;  // acked
        end
        efpga_pkg::evt_release: begin
          if (!send_sync_q2) state_q <= efpga_pkg::evt_idle;
        end
        default: state_q <= efpga_pkg::evt_idle;
      endcase
    end
  end

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      send_sync_q1  <= 1'b0;
      send_sync_q2  <= 1'b0;
      ack_prev_q    <= 1'b0;
      event_pulse_o <= 1'b0;
    end else begin
      send_sync_q1  <= (state_q == efpga_pkg::evt_send);
      send_sync_q2  <= send_sync_q1;
      ack_prev_q    <= send_sync_q2;
      event_pulse_o <= send_sync_q2 & ~ack_prev_q;  // rising edge of synced level
    end
  end

endmodule

`default_nettype wire

/* hdl/lint_grant_gate.sv */
// grant throttle for the APB-lint port towards the fabric
// delayed grant when enabled, grant and valid forced when disabled

`timescale 1ns/1ps
`default_nettype none

`include "efpga_defines.svh"

module lint_grant_gate (
  input  wire logic             asic_clk_i,
  input  wire logic             rst_n,
  input  wire logic             enable_i,
  input  wire logic             lint_req_i,
  output logic                  lint_gnt_o,
  output logic                  lint_r_valid_o,
  output efpga_pkg::data_t      lint_rdata_o,
  output logic                  fab_req_o,
  input  wire logic             fab_gnt_i,
  input  wire logic             fab_r_valid_i,
  input  wire efpga_pkg::data_t fab_rdata_i
);

  logic [`LINT_GNT_DELAY-1:0] req_hist_q;
  logic                       hold_early;

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      req_hist_q <= '0;
    end else if (!lint_req_i) begin
      req_hist_q <= '0;  // restart on any gap
    end else begin
      req_hist_q <= {req_hist_q[`LINT_GNT_DELAY-2:0], 1'b1};
    end
  end

  // fabric only sees the first cycle of a held request
  assign hold_early = req_hist_q[0] | req_hist_q[1];

  assign fab_req_o      = enable_i & lint_req_i & ~hold_early;
  assign lint_gnt_o     = enable_i ? (req_hist_q[`LINT_GNT_DELAY-1] & fab_gnt_i) : lint_req_i;
  assign lint_r_valid_o = enable_i ? fab_r_valid_i : 1'b1;
  assign lint_rdata_o   = fab_rdata_i;

endmodule

`default_nettype wire

/* hdl/tcdm_port_if.sv */
// fabric-side TCDM request bundle
// fabric drives the request, the slice answers with grant and read data

`timescale 1ns/1ps
`default_nettype none

interface tcdm_port_if;

  logic                  req;
  logic                  wen;    // high means read
  efpga_pkg::fpga_addr_t addr;
  efpga_pkg::be_t        be;
  efpga_pkg::data_t      wdata;
  logic                  gnt;
  logic                  r_valid;
  efpga_pkg::data_t      rdata;

  modport fabric (
    output req, wen, addr, be, wdata,
    input  gnt, r_valid, rdata
  );

  modport slice (
    input  req, wen, addr, be, wdata,
    output gnt, r_valid, rdata
  );

endinterface

`default_nettype wire

/* hdl/tcdm_port_slice.sv */
// one-entry request slice from a fabric TCDM master to a SoC port
// adds the fixed address base and qualifies read valid by the last granted wen

`timescale 1ns/1ps
`default_nettype none

`include "efpga_defines.svh"

module tcdm_port_slice (
  input  wire logic              asic_clk_i,
  input  wire logic              rst_n,
  input  wire logic              enable_i,
  tcdm_port_if.slice             fab,
  output logic                   soc_req_o,
  output efpga_pkg::soc_addr_t   soc_addr_o,
  output logic                   soc_wen_o,
  output efpga_pkg::be_t         soc_be_o,
  output efpga_pkg::data_t       soc_wdata_o,
  input  wire logic              soc_gnt_i,
  input  wire logic              soc_r_valid_i,
  input  wire efpga_pkg::data_t  soc_rdata_i
);

  logic                  full_q;
  logic                  wen_q;
  logic                  last_wen_q;
  efpga_pkg::fpga_addr_t addr_q;
  efpga_pkg::be_t        be_q;
  efpga_pkg::data_t      wdata_q;
  logic                  accept;
  logic                  soc_done;

  assign soc_done = full_q & soc_gnt_i;  // held request taken by the SoC
  assign fab.gnt  = enable_i & (~full_q | soc_gnt_i);
  assign accept   = fab.req & fab.gnt;

  always_ff @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      full_q     <= 1'b0;
      last_wen_q <= 1'b1;  // read
    end else begin
      if (accept) begin
        full_q <= 1'b1;
      end else if (soc_done) begin
        full_q <= 1'b0;
      end
      if (soc_done) begin
        last_wen_q <= wen_q;
      end
    end
  end

  always_ff @(posedge asic_clk_i) begin
    if (accept) begin
      wen_q   <= fab.wen;
      addr_q  <= fab.addr;
      be_q    <= fab.be;
      wdata_q <= fab.wdata;
    end
  end

  assign soc_req_o   = full_q;
  assign soc_addr_o  = {`TCDM_BASE_HI, addr_q};
  assign soc_wen_o   = wen_q;
  assign soc_be_o    = be_q;
  assign soc_wdata_o = wdata_q;

  // write responses are not forwarded
  assign fab.r_valid = soc_r_valid_i & last_wen_q;
  assign fab.rdata   = soc_rdata_i;

endmodule

`default_nettype wire

/* include/efpga_defines.svh */
// eFPGA glue sizes, counts and fixed address base
// widths shared by the package, the slices and the top level

`ifndef EFPGA_DEFINES_SVH
`define EFPGA_DEFINES_SVH

`define EFPGA_TCDM_PORTS 4   // fabric TCDM masters
`define EFPGA_EVENTS     16  // fabric event lines

`define EFPGA_DATA_W 32
`define EFPGA_BE_W   4
`define EFPGA_ADDR_W 20      // fabric-side offset
`define SOC_ADDR_W   32

// upper SoC address bits above the fabric offset
`define TCDM_BASE_HI 12'h1C0

`define LINT_GNT_DELAY 5     // held lint req cycles before grant

`endif

/* tb/tb_efpga_subsystem.sv */
// testbench for the eFPGA glue: control filter, TCDM slices, lint gate, events
// random SoC and fabric models, reference models and assertions

`timescale 1ns/1ps
`default_nettype none

`include "efpga_defines.svh"

module tb_efpga_subsystem;

  localparam int P = `EFPGA_TCDM_PORTS;

  logic                                asic_clk_i;
  logic                                rst_n;
  efpga_pkg::control_word_t            control_in_i;
  efpga_pkg::control_word_t            control_word_o;
  logic [P-1:0]                        enable_tcdm_i;
  logic                                enable_apb_i;
  logic                                enable_events_i;
  logic [P-1:0]                        fab_tcdm_req_i;
  logic [P-1:0]                        fab_tcdm_wen_i;
  efpga_pkg::fpga_addr_t [P-1:0]       fab_tcdm_addr_i;
  efpga_pkg::be_t [P-1:0]              fab_tcdm_be_i;
  efpga_pkg::data_t [P-1:0]            fab_tcdm_wdata_i;
  logic [P-1:0]                        fab_tcdm_gnt_o;
  logic [P-1:0]                        fab_tcdm_r_valid_o;
  efpga_pkg::data_t [P-1:0]            fab_tcdm_rdata_o;
  logic [P-1:0]                        soc_tcdm_req_o;
  efpga_pkg::soc_addr_t [P-1:0]        soc_tcdm_addr_o;
  logic [P-1:0]                        soc_tcdm_wen_o;
  efpga_pkg::be_t [P-1:0]              soc_tcdm_be_o;
  efpga_pkg::data_t [P-1:0]            soc_tcdm_wdata_o;
  logic [P-1:0]                        soc_tcdm_gnt_i;
  logic [P-1:0]                        soc_tcdm_r_valid_i;
  efpga_pkg::data_t [P-1:0]            soc_tcdm_rdata_i;
  logic                                lint_req_i;
  logic                                lint_wen_i;
  efpga_pkg::fpga_addr_t               lint_addr_i;
  efpga_pkg::be_t                      lint_be_i;
  efpga_pkg::data_t                    lint_wdata_i;
  logic                                lint_gnt_o;
  logic                                lint_r_valid_o;
  efpga_pkg::data_t                    lint_rdata_o;
  logic                                fab_lint_req_o;
  logic                                fab_lint_wen_o;
  efpga_pkg::fpga_addr_t               fab_lint_addr_o;
  efpga_pkg::be_t                      fab_lint_be_o;
  efpga_pkg::data_t                    fab_lint_wdata_o;
  logic                                fab_lint_gnt_i;
  logic                                fab_lint_r_valid_i;
  efpga_pkg::data_t                    fab_lint_rdata_i;
  efpga_pkg::event_vec_t               events_i;
  efpga_pkg::event_vec_t               efpga_event_o;

  // reference models and bookkeeping
  int                       errors;
  int                       pulses;
  int                       xfers [P];
  logic                     tcdm_run;
  logic                     fab_taken [P];
  logic                     soc_taken [P];
  logic                     exp_full [P];
  logic                     exp_wen [P];
  efpga_pkg::fpga_addr_t    exp_addr [P];
  efpga_pkg::be_t           exp_be [P];
  efpga_pkg::data_t         exp_wdata [P];
  logic                     last_wen_m [P];
  efpga_pkg::soc_addr_t     resp_addr_m [P];
  efpga_pkg::soc_addr_t     soc_grant_addr [P];  // address the SoC model granted
  logic [68:0]              soc_exp;
  logic [68:0]              soc_act;
  efpga_pkg::control_word_t ctl_hist [3];
  efpga_pkg::control_word_t ctl_model;
  int                       lint_run;  // consecutive cycles of lint_req before this one
  efpga_pkg::event_vec_t    evt_gated_m;
  efpga_pkg::event_vec_t    evt_prev_m;
  efpga_pkg::event_vec_t    rise_pipe [4];

  efpga_subsystem i_efpga_subsystem (.*);

  initial begin
    asic_clk_i = 1'b0;
    forever #2 asic_clk_i = ~asic_clk_i;
  end

  function automatic efpga_pkg::data_t read_word(input efpga_pkg::soc_addr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5A5A_0F0F;
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("error: %s", msg);
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
    errors++;
    $display("mismatch %s: expected %0h actual %0h", name, expected, actual);
  endtask

  assign evt_gated_m = events_i & {`EFPGA_EVENTS{enable_events_i}};

  always @(posedge asic_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ctl_hist   <= '{default: '0};
      ctl_model  <= '0;
      lint_run   <= 0;
      evt_prev_m <= '0;
      rise_pipe  <= '{default: '0};
    end else begin
      ctl_hist[0] <= control_in_i;
      ctl_hist[1] <= ctl_hist[0];
      ctl_hist[2] <= ctl_hist[1];
      if (ctl_hist[0] == ctl_hist[1] && ctl_hist[1] == ctl_hist[2]) begin
        ctl_model <= ctl_hist[0];  // three equal samples
      end
      lint_run     <= lint_req_i ? ((lint_run < 15) ? lint_run + 1 : lint_run) : 0;
      evt_prev_m   <= evt_gated_m;
      rise_pipe[0] <= evt_gated_m & ~evt_prev_m;
      rise_pipe[1] <= rise_pipe[0];
      rise_pipe[2] <= rise_pipe[1];
      rise_pipe[3] <= rise_pipe[2];
    end
  end

  // TCDM scoreboard, one held request per port
  always @(posedge asic_clk_i) begin
    if (!rst_n) begin
      for (int p = 0; p < P; p++) begin
        exp_full[p]   = 1'b0;
        last_wen_m[p] = 1'b1;
        fab_taken[p]  = 1'b0;
        soc_taken[p]  = 1'b0;
      end
    end else begin
      pulses += $countones(efpga_event_o);
      for (int p = 0; p < P; p++) begin
        soc_exp = {`TCDM_BASE_HI, exp_addr[p], exp_wen[p], exp_be[p], exp_wdata[p]};
        soc_act = {soc_tcdm_addr_o[p], soc_tcdm_wen_o[p], soc_tcdm_be_o[p], soc_tcdm_wdata_o[p]};
        if (soc_tcdm_req_o[p]) begin
          assert (exp_full[p])
            else flag_error($sformatf("port %0d raised a SoC request nobody issued", p));
          assert (soc_act == soc_exp)
            else report_mismatch($sformatf("tcdm forward port %0d", p), soc_exp, soc_act);
        end
        assert (fab_tcdm_r_valid_o[p] == (soc_tcdm_r_valid_i[p] & last_wen_m[p]))
          else report_mismatch($sformatf("read valid port %0d", p),
                               soc_tcdm_r_valid_i[p] & last_wen_m[p], fab_tcdm_r_valid_o[p]);
        if (fab_tcdm_r_valid_o[p]) begin
          assert (fab_tcdm_rdata_o[p] == read_word(resp_addr_m[p]))
            else report_mismatch($sformatf("read data port %0d", p),
                                 read_word(resp_addr_m[p]), fab_tcdm_rdata_o[p]);
        end
        soc_taken[p] = soc_tcdm_req_o[p] & soc_tcdm_gnt_i[p];
        if (soc_taken[p]) begin
          last_wen_m[p]     = exp_wen[p];
          resp_addr_m[p]    = {`TCDM_BASE_HI, exp_addr[p]};
          soc_grant_addr[p] = soc_tcdm_addr_o[p];
          exp_full[p]       = 1'b0;
          xfers[p]++;
        end
        fab_taken[p] = fab_tcdm_req_i[p] & fab_tcdm_gnt_o[p];
        if (fab_taken[p]) begin
          exp_wen[p]   = fab_tcdm_wen_i[p];
          exp_addr[p]  = fab_tcdm_addr_i[p];
          exp_be[p]    = fab_tcdm_be_i[p];
          exp_wdata[p] = fab_tcdm_wdata_i[p];
          exp_full[p]  = 1'b1;
        end
      end
    end
  end

  for (genvar p = 0; p < P; p++) begin : g_port_check
    assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      soc_tcdm_req_o[p] && !soc_tcdm_gnt_i[p] |-> !fab_tcdm_gnt_o[p])
      else flag_error($sformatf("port %0d granted the fabric under SoC back-pressure", p));
    assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      enable_tcdm_i[p] && !soc_tcdm_req_o[p] |-> fab_tcdm_gnt_o[p])
      else flag_error($sformatf("port %0d refused a request while empty", p));
    assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      !enable_tcdm_i[p] |-> !fab_tcdm_gnt_o[p])
      else flag_error($sformatf("disabled port %0d granted a request", p));
    assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      fab_tcdm_req_i[p] && fab_tcdm_gnt_o[p] |=> soc_tcdm_req_o[p])
      else flag_error($sformatf("port %0d did not forward an accepted request", p));
  end

  assert property (@(posedge asic_clk_i) disable iff (!rst_n) control_word_o == ctl_model)
    else report_mismatch("control filter", $sampled(ctl_model), $sampled(control_word_o));
  assert property (@(posedge asic_clk_i) disable iff (!rst_n)
    !enable_apb_i |-> lint_gnt_o == lint_req_i && lint_r_valid_o && !fab_lint_req_o)
    else flag_error("lint bypass broke grant, valid or fabric request");
  assert property (@(posedge asic_clk_i) disable iff (!rst_n)
    enable_apb_i && lint_gnt_o |-> lint_run >= 4)
    else flag_error("lint grant came before the fifth cycle of a held request");
  assert property (@(posedge asic_clk_i) disable iff (!rst_n)
    enable_apb_i |-> fab_lint_req_o == (lint_req_i && lint_run == 0))
    else flag_error("fabric lint request outside the first cycle of a held request");
  assert property (@(posedge asic_clk_i) disable iff (!rst_n)
    enable_apb_i |-> lint_r_valid_o == fab_lint_r_valid_i && lint_rdata_o == fab_lint_rdata_i)
    else flag_error("lint read response not taken from the fabric");
  assert property (@(posedge asic_clk_i) disable iff (!rst_n)
    {fab_lint_wen_o, fab_lint_addr_o, fab_lint_be_o, fab_lint_wdata_o} ==
    {lint_wen_i, lint_addr_i, lint_be_i, lint_wdata_i})
    else flag_error("lint payload changed on its way to the fabric");
  assert property (@(posedge asic_clk_i) disable iff (!rst_n) efpga_event_o == rise_pipe[3])
    else report_mismatch("event pulses", $sampled(rise_pipe[3]), $sampled(efpga_event_o));

  // random fabric masters and a responsive SoC
  initial begin
    void'($urandom(22));
    fab_tcdm_req_i     = '0;
    fab_tcdm_wen_i     = '0;
    fab_tcdm_addr_i    = '0;
    fab_tcdm_be_i      = '0;
    fab_tcdm_wdata_i   = '0;
    soc_tcdm_gnt_i     = '0;
    soc_tcdm_r_valid_i = '0;
    soc_tcdm_rdata_i   = '0;
    forever begin
      @(negedge asic_clk_i);
      for (int p = 0; p < P; p++) begin
        soc_tcdm_gnt_i[p]     = ($urandom_range(99) < 60);
        soc_tcdm_r_valid_i[p] = soc_taken[p];  // one cycle after each SoC grant
        soc_tcdm_rdata_i[p]   = soc_taken[p] ? read_word(soc_grant_addr[p]) : $urandom;
        if (fab_taken[p] || !fab_tcdm_req_i[p]) begin
          fab_tcdm_req_i[p]   = tcdm_run && ($urandom_range(3) != 0);
          fab_tcdm_wen_i[p]   = $urandom_range(1);
          fab_tcdm_addr_i[p]  = $urandom;
          fab_tcdm_be_i[p]    = $urandom;
          fab_tcdm_wdata_i[p] = $urandom;
        end
      end
    end
  end

  task automatic hold_control(input efpga_pkg::control_word_t v, input int cycles);
    control_in_i = v;
    repeat (cycles) @(negedge asic_clk_i);
  endtask

  task automatic expect_control(input efpga_pkg::control_word_t v);
    assert (control_word_o == v) else report_mismatch("control hold", v, control_word_o);
  endtask

  task automatic wait_transfers(input logic [P-1:0] ports, input int target);
    int  n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done && n < 4000) begin
      @(negedge asic_clk_i);
      n++;
      done = 1'b1;
      for (int p = 0; p < P; p++) begin
        if (ports[p] && xfers[p] < target) done = 1'b0;
      end
    end
    if (!done) flag_error("timeout waiting for TCDM transfers");
  endtask

  task automatic wait_tcdm_idle();
    int n;
    n = 0;
    while ((soc_tcdm_req_o != '0 || fab_tcdm_req_i != '0) && n < 500) begin
      @(negedge asic_clk_i);
      n++;
    end
    if (soc_tcdm_req_o != '0 || fab_tcdm_req_i != '0) flag_error("TCDM ports never drained");
  endtask

  task automatic lint_access(input efpga_pkg::fpga_addr_t addr, input logic wen);
    int n;
    n            = 0;
    lint_req_i   = 1'b1;
    lint_wen_i   = wen;
    lint_addr_i  = addr;
    lint_be_i    = 4'hF;
    lint_wdata_i = {12'h0, addr};
    @(negedge asic_clk_i);
    while (!lint_gnt_o && n < 20) begin
      @(negedge asic_clk_i);
      n++;
    end
    if (!lint_gnt_o) flag_error("timeout waiting for the lint grant");
    @(negedge asic_clk_i);  // grant taken on the edge before
    lint_req_i         = 1'b0;
    fab_lint_r_valid_i = 1'b1;
    fab_lint_rdata_i   = read_word({`TCDM_BASE_HI, addr});
    @(negedge asic_clk_i);
    fab_lint_r_valid_i = 1'b0;
  endtask

  task automatic raise_events(input efpga_pkg::event_vec_t bits);
    events_i = bits;
    repeat (3) @(negedge asic_clk_i);
    events_i = '0;
    repeat (9) @(negedge asic_clk_i);  // channel back in idle
  endtask

  initial begin
    errors = 0;
    pulses = 0;
    xfers = '{default: 0};
    tcdm_run = 1'b0;
    rst_n = 1'b0;
    control_in_i = '0;
    enable_tcdm_i = '0;
    enable_apb_i = 1'b0;
    enable_events_i = 1'b0;
    lint_req_i = 1'b0;
    lint_wen_i = 1'b0;
    lint_addr_i = '0;
    lint_be_i = '0;
    lint_wdata_i = '0;
    fab_lint_gnt_i = 1'b0;
    fab_lint_r_valid_i = 1'b0;
    fab_lint_rdata_i = '0;
    events_i = '0;
    repeat (3) @(posedge asic_clk_i);
    @(negedge asic_clk_i);
    rst_n = 1'b1;
    repeat (2) @(negedge asic_clk_i);

    hold_control(32'h1234_5678, 6);
    expect_control(32'h1234_5678);
    hold_control(32'hDEAD_0001, 1);  // one-cycle glitch
    hold_control(32'h1234_5678, 4);
    expect_control(32'h1234_5678);
    hold_control(32'hDEAD_0002, 2);
    hold_control(32'h1234_5678, 4);
    expect_control(32'h1234_5678);
    hold_control(32'h0F0F_A5A5, 4);
    expect_control(32'h0F0F_A5A5);

    enable_tcdm_i = 4'b1011;
    tcdm_run = 1'b1;
    wait_transfers(4'b1011, 24);
    assert (xfers[2] == 0) else report_mismatch("disabled port transfers", 0, xfers[2]);
    enable_tcdm_i = 4'b1111;
    wait_transfers(4'b1111, 24);
    tcdm_run = 1'b0;
    wait_tcdm_idle();

    for (int i = 0; i < 8; i++) begin
      lint_req_i = i[0] ^ i[2];
      lint_addr_i = 20'h00100 + i;
      @(negedge asic_clk_i);
    end
    lint_req_i = 1'b0;
    enable_apb_i = 1'b1;
    fab_lint_gnt_i = 1'b1;
    lint_access(20'h00040, 1'b1);
    lint_access(20'h0ABCD, 1'b0);
    for (int burst = 1; burst <= 4; burst++) begin
      lint_req_i = 1'b1;
      repeat (burst) @(negedge asic_clk_i);
      lint_req_i = 1'b0;
      @(negedge asic_clk_i);
    end

    enable_events_i = 1'b1;
    for (int b = 0; b < `EFPGA_EVENTS; b++) raise_events(16'h0001 << b);
    raise_events(16'h8001);
    assert (pulses == 18) else report_mismatch("event pulse count", 18, pulses);
    enable_events_i = 1'b0;
    raise_events(16'hFFFF);
    repeat (4) @(negedge asic_clk_i);

    $display("errors %0d, tcdm transfers %0d %0d %0d %0d, event pulses %0d",
             errors, xfers[0], xfers[1], xfers[2], xfers[3], pulses);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
